/* list.f */
+incdir+common
common/core_pkg.sv
design/fetch_unit.sv
design/pipeline_control.sv
decode/regfile.sv
decode/decode_stage.sv
execute/execute_stage.sv
design/rv_core.sv
verif/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rv_core testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_rv_core -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_rv_core" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Test failed" "$LOG_FILE"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

echo "simulation finished cleanly"
exit 0

/* verif/tb_rv_core.sv */
`include "core_config.svh"

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  import core_pkg::*;

  localparam int    IMEM_WORDS     = 64;
  localparam int    HALT_INDEX     = IMEM_WORDS - 1;
  localparam word_t HALT_PC        = word_t'(HALT_INDEX * 4);
  localparam int    TIMEOUT_CYCLES = IMEM_WORDS * 4 + 50;
  localparam word_t NOP_WORD       = 32'h0000_0013;

  // instruction kinds kept by the generator for the model
  localparam int K_OP     = 0;
  localparam int K_OP_IMM = 1;
  localparam int K_LUI    = 2;
  localparam int K_BRANCH = 3;
  localparam int K_JAL    = 4;

  logic      CLK;
  logic      RST;
  word_t     fetch_addr;
  word_t     fetch_insn;
  logic      retire_valid;
  word_t     retire_pc;
  reg_addr_t retire_rd_addr;
  word_t     retire_rd_wdata;

  // program image and the fields it was built from
  word_t imem     [IMEM_WORDS];
  int    kind_mem [IMEM_WORDS];
  int    f3_mem   [IMEM_WORDS];
  int    alt_mem  [IMEM_WORDS];
  int    rd_mem   [IMEM_WORDS];
  int    rs1_mem  [IMEM_WORDS];
  int    rs2_mem  [IMEM_WORDS];
  word_t imm_mem  [IMEM_WORDS];

  // expected retire records in program order
  word_t exp_pc_q   [$];
  word_t exp_rd_q   [$];
  word_t exp_data_q [$];

  logic [31:0] lfsr_state   = 32'd82059;
  word_t       pending_addr = `CORE_START_ADDR;
  int          cycle_count  = 0;

  rv_core rv_core_i (
    .CLK               (CLK),
    .RST               (RST),
    .fetch_addr_o      (fetch_addr),
    .fetch_insn_i      (fetch_insn),
    .retire_valid_o    (retire_valid),
    .retire_pc_o       (retire_pc),
    .retire_rd_addr_o  (retire_rd_addr),
    .retire_rd_wdata_o (retire_rd_wdata)
  );

  always #5 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // random source and instruction encoding
  ////////////////////////////////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int k = 0; k < n; k++) begin
      r = (r << 1) | int'(lfsr_step());
    end
    return r;
  endfunction

  // r-type and i-type share this layout
  function automatic word_t alu_word(input logic [6:0] hi7, input logic [4:0] lo5,
                                     input int rs1, input int f3, input int rd,
                                     input logic [6:0] opc);
    return {hi7, lo5, 5'(rs1), 3'(f3), 5'(rd), opc};
  endfunction

  function automatic word_t branch_word(input int off, input int rs2, input int rs1,
                                        input int f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic word_t jal_word(input int off, input int rd);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference semantics
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t alu_ref(input int f3, input int alt, input word_t a,
                                    input word_t b);
    case (f3)
      0:       return (alt != 0) ? a - b : a + b;
      1:       return a << b[4:0];
      2:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3:       return (a < b) ? 32'd1 : 32'd0;
      4:       return a ^ b;
      5:       return (alt != 0) ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6:       return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input int f3, input word_t a, input word_t b);
    case (f3)
      0:       return a == b;
      1:       return a != b;
      4:       return $signed(a) < $signed(b);
      default: return $signed(a) >= $signed(b);
    endcase
  endfunction

  function automatic word_t imem_read(input word_t addr);
    if (addr >= word_t'(IMEM_WORDS * 4)) begin
      return NOP_WORD;
    end
    return imem[addr[7:2]];
  endfunction

  task automatic build_program();
    int    cls;
    int    f3;
    int    alt;
    int    rd;
    int    rs1;
    int    rs2;
    int    off;
    word_t imm;
    for (int i = 0; i < HALT_INDEX; i++) begin
      cls = rand_bits(3);
      rd  = rand_bits(3);
      rs1 = rand_bits(3);
      rs2 = rand_bits(3);
      f3  = rand_bits(3);
      alt = 0;
      imm = '0;
      if (cls <= 2) begin
        // bit 30 picks sub and sra
        if (f3 == 0 || f3 == 5) begin
          alt = rand_bits(1);
        end
        kind_mem[i] = K_OP;
        imem[i] = alu_word(7'(alt << 5), 5'(rs2), rs1, f3, rd, 7'b0110011);
      end else if (cls <= 4) begin
        kind_mem[i] = K_OP_IMM;
        if (f3 == 1 || f3 == 5) begin
          if (f3 == 5) begin
            alt = rand_bits(1);
          end
          imm = word_t'(rand_bits(5));
          imem[i] = alu_word(7'(alt << 5), imm[4:0], rs1, f3, rd, 7'b0010011);
        end else begin
          imm = word_t'(rand_bits(12));
          imm = {{20{imm[11]}}, imm[11:0]};
          imem[i] = alu_word(imm[11:5], imm[4:0], rs1, f3, rd, 7'b0010011);
        end
      end else if (cls == 5) begin
        kind_mem[i] = K_LUI;
        imm = word_t'(rand_bits(20)) << 12;
        imem[i] = {imm[31:12], 5'(rd), 7'b0110111};
      end else begin
        // forward only and never past the halt word
        off = 1 + rand_bits(2);
        if (i + off > HALT_INDEX) begin
          off = HALT_INDEX - i;
        end
        imm = word_t'(off * 4);
        if (f3 == 2 || f3 == 3) begin
          kind_mem[i] = K_JAL;
          imem[i] = jal_word(off * 4, rd);
        end else begin
          f3 = f3 & 5;
          rd = 0;
          kind_mem[i] = K_BRANCH;
          imem[i] = branch_word(off * 4, rs2, rs1, f3);
        end
      end
      f3_mem[i]  = f3;
      alt_mem[i] = alt;
      rd_mem[i]  = rd;
      rs1_mem[i] = rs1;
      rs2_mem[i] = rs2;
      imm_mem[i] = imm;
    end
    // halt is jal x0 onto itself
    kind_mem[HALT_INDEX] = K_JAL;
    f3_mem[HALT_INDEX]   = 0;
    alt_mem[HALT_INDEX]  = 0;
    rd_mem[HALT_INDEX]   = 0;
    rs1_mem[HALT_INDEX]  = 0;
    rs2_mem[HALT_INDEX]  = 0;
    imm_mem[HALT_INDEX]  = '0;
    imem[HALT_INDEX]     = jal_word(0, 0);
  endtask

  // architectural run of the program with one record per retired instruction
  task automatic run_model();
    word_t xreg [32];
    word_t pc;
    word_t next_pc;
    word_t val;
    word_t src_a;
    word_t src_b;
    int    idx;
    int    rd;
    for (int r = 0; r < 32; r++) begin
      xreg[r] = '0;
    end
    pc = `CORE_START_ADDR;
    do begin
      idx     = int'(pc >> 2);
      src_a   = xreg[rs1_mem[idx]];
      src_b   = xreg[rs2_mem[idx]];
      rd      = rd_mem[idx];
      val     = '0;
      next_pc = pc + 32'd4;
      case (kind_mem[idx])
        K_OP:     val = alu_ref(f3_mem[idx], alt_mem[idx], src_a, src_b);
        K_OP_IMM: val = alu_ref(f3_mem[idx], alt_mem[idx], src_a, imm_mem[idx]);
        K_LUI:    val = imm_mem[idx];
        K_BRANCH: begin
          if (branch_taken(f3_mem[idx], src_a, src_b)) begin
            next_pc = pc + imm_mem[idx];
          end
        end
        default: begin
          val     = pc + 32'd4;
          next_pc = pc + imm_mem[idx];
        end
      endcase
      if (rd == 0) begin
        val = '0;
      end
      exp_pc_q.push_back(pc);
      exp_rd_q.push_back(word_t'(rd));
      exp_data_q.push_back(val);
      // x0 only ever receives zero
      xreg[rd] = val;
      pc = next_pc;
    end while (idx != HALT_INDEX);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  initial begin
    CLK        = 1'b0;
    RST        = 1'b1;
    fetch_insn = NOP_WORD;
    build_program();
    run_model();
    repeat (8) begin
      @(posedge CLK);
      #1;
      check_value("retire_valid_o", '0, word_t'(retire_valid));
      check_value("fetch_addr_o", `CORE_START_ADDR, fetch_addr);
    end
    RST = 1'b0;
    @(posedge CLK);
    #1;
    // first edge out of reset steps the pc
    check_value("retire_valid_o", '0, word_t'(retire_valid));
    check_value("fetch_addr_o", `CORE_START_ADDR + `CORE_PC_STEP, fetch_addr);
  end

  // return the word for last cycle's address and capture this cycle's
  always @(posedge CLK) begin
    #1;
    fetch_insn   = imem_read(pending_addr);
    pending_addr = fetch_addr;
  end

  // retire port is stable at the falling edge
  always @(negedge CLK) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run("halt instruction did not retire within the cycle limit");
    end
    if (!RST && retire_valid) begin
      if (exp_pc_q.size() == 0) begin
        abort_run("an instruction retired with no expected record left");
      end
      check_value("retire_pc_o", exp_pc_q.pop_front(), retire_pc);
      check_value("retire_rd_addr_o", exp_rd_q.pop_front(), word_t'(retire_rd_addr));
      check_value("retire_rd_wdata_o", exp_data_q.pop_front(), retire_rd_wdata);
      if (retire_pc == HALT_PC) begin
        if (exp_pc_q.size() == 0) begin
          $display("Test passed");
          $finish;
        end else begin
          abort_run("halt retired while expected records were still queued");
        end
      end
    end
  end

endmodule

/* design/rv_core.sv */
module rv_core (
  input  logic               CLK,
  input  logic               RST,
  output core_pkg::word_t     fetch_addr_o,
  input  core_pkg::word_t     fetch_insn_i,
  output logic               retire_valid_o,
  output core_pkg::word_t     retire_pc_o,
  output core_pkg::reg_addr_t retire_rd_addr_o,
  output core_pkg::word_t     retire_rd_wdata_o
);
  import core_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // stage wires
  ////////////////////////////////////////////////////////////////////////////

  // fetch to decode
  logic       id_valid;
  word_t      id_pc;
  word_t      id_insn;

  // decode and register file
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  word_t      rs1_rdata;
  word_t      rs2_rdata;
  logic       bypass_a;
  logic       bypass_b;

  // decode to execute
  logic       ex_valid;
  word_t      ex_pc;
  reg_addr_t  ex_rs1_addr;
  reg_addr_t  ex_rs2_addr;
  reg_addr_t  ex_rd_addr;
  word_t      ex_rs1;
  word_t      ex_rs2;
  imm_t       ex_imm;
  alu_op_t    ex_alu_op;
  branch_op_t ex_branch_op;
  logic       ex_use_imm;

  // execute results and control
  fwd_sel_t   fwd_a;
  fwd_sel_t   fwd_b;
  logic       redirect;
  word_t      target;
  logic       flush;
  logic       wb_valid;
  word_t      wb_pc;
  reg_addr_t  wb_rd_addr;
  word_t      wb_wdata;

  fetch_unit fetch_unit_i (
    .CLK          (CLK),
    .RST          (RST),
    .redirect_i   (redirect),
    .target_i     (target),
    .flush_i      (flush),
    .fetch_insn_i (fetch_insn_i),
    .fetch_addr_o (fetch_addr_o),
    .id_valid_o   (id_valid),
    .id_pc_o      (id_pc),
    .id_insn_o    (id_insn)
  );

  decode_stage decode_stage_i (
    .CLK            (CLK),
    .RST            (RST),
    .flush_i        (flush),
    .id_valid_i     (id_valid),
    .id_pc_i        (id_pc),
    .id_insn_i      (id_insn),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .rs1_rdata_i    (rs1_rdata),
    .rs2_rdata_i    (rs2_rdata),
    .bypass_a_i     (bypass_a),
    .bypass_b_i     (bypass_b),
    .wb_wdata_i     (wb_wdata),
    .ex_valid_o     (ex_valid),
    .ex_pc_o        (ex_pc),
    .ex_rs1_addr_o  (ex_rs1_addr),
    .ex_rs2_addr_o  (ex_rs2_addr),
    .ex_rd_addr_o   (ex_rd_addr),
    .ex_rs1_o       (ex_rs1),
    .ex_rs2_o       (ex_rs2),
    .ex_imm_o       (ex_imm),
    .ex_alu_op_o    (ex_alu_op),
    .ex_branch_op_o (ex_branch_op),
    .ex_use_imm_o   (ex_use_imm)
  );

  // written from the writeback register at the end of its cycle
  regfile regfile_i (
    .CLK         (CLK),
    .RST         (RST),
    .rs1_addr_i  (rs1_addr),
    .rs2_addr_i  (rs2_addr),
    .rs1_rdata_o (rs1_rdata),
    .rs2_rdata_o (rs2_rdata),
    .rd_addr_i   (wb_rd_addr),
    .rd_wdata_i  (wb_wdata),
    .we_i        (wb_valid)
  );

  execute_stage execute_stage_i (
    .CLK            (CLK),
    .RST            (RST),
    .ex_valid_i     (ex_valid),
    .ex_pc_i        (ex_pc),
    .ex_rd_addr_i   (ex_rd_addr),
    .ex_rs1_i       (ex_rs1),
    .ex_rs2_i       (ex_rs2),
    .ex_imm_i       (ex_imm),
    .ex_alu_op_i    (ex_alu_op),
    .ex_branch_op_i (ex_branch_op),
    .ex_use_imm_i   (ex_use_imm),
    .fwd_a_i        (fwd_a),
    .fwd_b_i        (fwd_b),
    .redirect_o     (redirect),
    .target_o       (target),
    .wb_valid_o     (wb_valid),
    .wb_pc_o        (wb_pc),
    .wb_rd_addr_o   (wb_rd_addr),
    .wb_wdata_o     (wb_wdata)
  );

  pipeline_control pipeline_control_i (
    .id_rs1_addr_i (rs1_addr),
    .id_rs2_addr_i (rs2_addr),
    .ex_rs1_addr_i (ex_rs1_addr),
    .ex_rs2_addr_i (ex_rs2_addr),
    .wb_rd_addr_i  (wb_rd_addr),
    .wb_valid_i    (wb_valid),
    .redirect_i    (redirect),
    .fwd_a_o       (fwd_a),
    .fwd_b_o       (fwd_b),
    .bypass_a_o    (bypass_a),
    .bypass_b_o    (bypass_b),
    .flush_o       (flush)
  );

  // writeback is the retire point
  assign retire_valid_o    = wb_valid;
  assign retire_pc_o       = wb_pc;
  assign retire_rd_addr_o  = wb_rd_addr;
  assign retire_rd_wdata_o = wb_wdata;

endmodule

/* execute/execute_stage.sv */
`include "core_config.svh"

module execute_stage (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 ex_valid_i,
  input  core_pkg::word_t      ex_pc_i,
  input  core_pkg::reg_addr_t  ex_rd_addr_i,
  input  core_pkg::word_t      ex_rs1_i,
  input  core_pkg::word_t      ex_rs2_i,
  input  core_pkg::imm_t       ex_imm_i,
  input  core_pkg::alu_op_t    ex_alu_op_i,
  input  core_pkg::branch_op_t ex_branch_op_i,
  input  logic                 ex_use_imm_i,
  input  core_pkg::fwd_sel_t   fwd_a_i,
  input  core_pkg::fwd_sel_t   fwd_b_i,
  output logic                 redirect_o,
  output core_pkg::word_t      target_o,
  output logic                 wb_valid_o,
  output core_pkg::word_t      wb_pc_o,
  output core_pkg::reg_addr_t  wb_rd_addr_o,
  output core_pkg::word_t      wb_wdata_o
);
  import core_pkg::*;

  word_t rs1_val;
  word_t rs2_val;
  word_t op_b;
  word_t alu_result;
  word_t result;
  logic  taken;

  function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t stage_val,
                                    input word_t wb_val);
    return (sel == FWD_WB) ? wb_val : stage_val;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // operands and alu
  ////////////////////////////////////////////////////////////////////////////

  assign rs1_val = fwd_mux(fwd_a_i, ex_rs1_i, wb_wdata_o);
  assign rs2_val = fwd_mux(fwd_b_i, ex_rs2_i, wb_wdata_o);
  assign op_b    = ex_use_imm_i ? ex_imm_i : rs2_val;

  always_comb begin
    case (ex_alu_op_i)
      ALU_SUB:    alu_result = rs1_val - op_b;
      ALU_AND:    alu_result = rs1_val & op_b;
      ALU_OR:     alu_result = rs1_val | op_b;
      ALU_XOR:    alu_result = rs1_val ^ op_b;
      ALU_SLT:    alu_result = {31'b0, $signed(rs1_val) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, rs1_val < op_b};
      ALU_SLL:    alu_result = rs1_val << op_b[4:0];
      ALU_SRL:    alu_result = rs1_val >> op_b[4:0];
      ALU_SRA:    alu_result = $signed(rs1_val) >>> op_b[4:0];
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = rs1_val + op_b;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // branch resolution
  ////////////////////////////////////////////////////////////////////////////

  // compares always use rs2, never the immediate
  always_comb begin
    case (ex_branch_op_i)
      BR_BEQ:  taken = rs1_val == rs2_val;
      BR_BNE:  taken = rs1_val != rs2_val;
      BR_BLT:  taken = $signed(rs1_val) < $signed(rs2_val);
      BR_BGE:  taken = $signed(rs1_val) >= $signed(rs2_val);
      BR_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign redirect_o = ex_valid_i && taken;
  assign target_o   = ex_pc_i + ex_imm_i;

  // jal links the return address
  assign result = (ex_branch_op_i == BR_JAL) ? ex_pc_i + `CORE_PC_STEP : alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // execute to writeback register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RST) begin
      wb_valid_o   <= 1'b0;
      wb_rd_addr_o <= '0;
    end else begin
      wb_valid_o   <= ex_valid_i;
      wb_rd_addr_o <= ex_valid_i ? ex_rd_addr_i : '0;
    end
  end

  // non-writing instructions retire with zero data
  always_ff @(posedge CLK) begin
    wb_pc_o    <= ex_pc_i;
    wb_wdata_o <= (ex_valid_i && ex_rd_addr_i != '0) ? result : '0;
  end

endmodule

/* decode/decode_stage.sv */
module decode_stage (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   flush_i,
  input  logic                   id_valid_i,
  input  core_pkg::word_t        id_pc_i,
  input  core_pkg::word_t        id_insn_i,
  output core_pkg::reg_addr_t    rs1_addr_o,
  output core_pkg::reg_addr_t    rs2_addr_o,
  input  core_pkg::word_t        rs1_rdata_i,
  input  core_pkg::word_t        rs2_rdata_i,
  input  logic                   bypass_a_i,
  input  logic                   bypass_b_i,
  input  core_pkg::word_t        wb_wdata_i,
  output logic                   ex_valid_o,
  output core_pkg::word_t        ex_pc_o,
  output core_pkg::reg_addr_t    ex_rs1_addr_o,
  output core_pkg::reg_addr_t    ex_rs2_addr_o,
  output core_pkg::reg_addr_t    ex_rd_addr_o,
  output core_pkg::word_t        ex_rs1_o,
  output core_pkg::word_t        ex_rs2_o,
  output core_pkg::imm_t         ex_imm_o,
  output core_pkg::alu_op_t      ex_alu_op_o,
  output core_pkg::branch_op_t   ex_branch_op_o,
  output logic                   ex_use_imm_o
);
  import core_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       rs1_used;
  logic       rs2_used;
  logic       rd_used;
  alu_op_t    alu_op;
  branch_op_t branch_op;
  logic       use_imm;
  imm_t       imm;
  word_t      rs1_val;
  word_t      rs2_val;

  // funct3 to alu op, alt selects sub or sra
  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = id_insn_i[6:0];
  assign funct3 = id_insn_i[14:12];

  ////////////////////////////////////////////////////////////////////////////
  // instruction decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rs1_used  = 1'b0;
    rs2_used  = 1'b0;
    rd_used   = 1'b0;
    alu_op    = ALU_ADD;
    branch_op = BR_NONE;
    use_imm   = 1'b0;
    imm       = '0;
    case (opcode)
      OPC_OP: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        rd_used  = 1'b1;
        alu_op   = alu_decode(funct3, id_insn_i[30]);
      end
      OPC_OP_IMM: begin
        rs1_used = 1'b1;
        rd_used  = 1'b1;
        use_imm  = 1'b1;
        // no subi, bit 30 only picks srai
        alu_op   = alu_decode(funct3, id_insn_i[30] && funct3 == 3'b101);
        imm      = {{20{id_insn_i[31]}}, id_insn_i[31:20]};
      end
      OPC_LUI: begin
        rd_used = 1'b1;
        use_imm = 1'b1;
        alu_op  = ALU_PASS_B;
        imm     = {id_insn_i[31:12], 12'b0};
      end
      OPC_BRANCH: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        imm      = {{19{id_insn_i[31]}}, id_insn_i[31], id_insn_i[7],
                    id_insn_i[30:25], id_insn_i[11:8], 1'b0};
        case (funct3)
          3'b000:  branch_op = BR_BEQ;
          3'b001:  branch_op = BR_BNE;
          3'b100:  branch_op = BR_BLT;
          3'b101:  branch_op = BR_BGE;
          default: branch_op = BR_NONE;
        endcase
      end
      OPC_JAL: begin
        rd_used   = 1'b1;
        branch_op = BR_JAL;
        imm       = {{11{id_insn_i[31]}}, id_insn_i[31], id_insn_i[19:12],
                     id_insn_i[20], id_insn_i[30:21], 1'b0};
      end
      // anything else passes through as a no-op
      default: ;
    endcase
  end

  assign rs1_addr_o = rs1_used ? id_insn_i[19:15] : '0;
  assign rs2_addr_o = rs2_used ? id_insn_i[24:20] : '0;

  // value being written this cycle is newer than the array
  assign rs1_val = bypass_a_i ? wb_wdata_i : rs1_rdata_i;
  assign rs2_val = bypass_b_i ? wb_wdata_i : rs2_rdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // decode to execute register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RST || flush_i || !id_valid_i) begin
      ex_valid_o     <= 1'b0;
      ex_rs1_addr_o  <= '0;
      ex_rs2_addr_o  <= '0;
      ex_rd_addr_o   <= '0;
      ex_branch_op_o <= BR_NONE;
    end else begin
      ex_valid_o     <= 1'b1;
      ex_rs1_addr_o  <= rs1_addr_o;
      ex_rs2_addr_o  <= rs2_addr_o;
      ex_rd_addr_o   <= rd_used ? id_insn_i[11:7] : '0;
      ex_branch_op_o <= branch_op;
    end
  end

  always_ff @(posedge CLK) begin
    ex_pc_o      <= id_pc_i;
    ex_rs1_o     <= rs1_val;
    ex_rs2_o     <= rs2_val;
    ex_imm_o     <= imm;
    ex_alu_op_o  <= alu_op;
    ex_use_imm_o <= use_imm;
  end

endmodule

/* decode/regfile.sv */
`include "core_config.svh"

module regfile (
  input  logic                CLK,
  input  logic                RST,
  input  core_pkg::reg_addr_t rs1_addr_i,
  input  core_pkg::reg_addr_t rs2_addr_i,
  output core_pkg::word_t     rs1_rdata_o,
  output core_pkg::word_t     rs2_rdata_o,
  input  core_pkg::reg_addr_t rd_addr_i,
  input  core_pkg::word_t     rd_wdata_i,
  input  logic                we_i
);
  import core_pkg::*;

  word_t regs [`CORE_NUM_REGS];

  // x0 is never written, so it stays at its reset value
  always_ff @(posedge CLK) begin
    if (RST) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_addr_i != '0) begin
      regs[rd_addr_i] <= rd_wdata_i;
    end
  end

  assign rs1_rdata_o = regs[rs1_addr_i];
  assign rs2_rdata_o = regs[rs2_addr_i];

  // execute zeroes the data of anything that does not write
  a_x0_data_zero: assert property (
    @(posedge CLK) disable iff (RST) (we_i && rd_addr_i == '0) |-> rd_wdata_i == '0
  );

endmodule

/* design/pipeline_control.sv */
module pipeline_control (
  input  core_pkg::reg_addr_t id_rs1_addr_i,
  input  core_pkg::reg_addr_t id_rs2_addr_i,
  input  core_pkg::reg_addr_t ex_rs1_addr_i,
  input  core_pkg::reg_addr_t ex_rs2_addr_i,
  input  core_pkg::reg_addr_t wb_rd_addr_i,
  input  logic                wb_valid_i,
  input  logic                redirect_i,
  output core_pkg::fwd_sel_t  fwd_a_o,
  output core_pkg::fwd_sel_t  fwd_b_o,
  output logic                bypass_a_o,
  output logic                bypass_b_o,
  output logic                flush_o
);
  import core_pkg::*;

  // writeback holds a result that will land in the register file
  logic wb_writes;

  assign wb_writes = wb_valid_i && (wb_rd_addr_i != '0);

  ////////////////////////////////////////////////////////////////////////////
  // forwarding into execute
  ////////////////////////////////////////////////////////////////////////////

  // producer sits exactly one instruction ahead
  always_comb begin
    fwd_a_o = FWD_NONE;
    fwd_b_o = FWD_NONE;
    if (wb_writes && (ex_rs1_addr_i == wb_rd_addr_i)) begin
      fwd_a_o = FWD_WB;
    end
    if (wb_writes && (ex_rs2_addr_i == wb_rd_addr_i)) begin
      fwd_b_o = FWD_WB;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bypass into decode
  ////////////////////////////////////////////////////////////////////////////

  // producer two ahead is being written this very cycle
  assign bypass_a_o = wb_writes && (id_rs1_addr_i == wb_rd_addr_i);
  assign bypass_b_o = wb_writes && (id_rs2_addr_i == wb_rd_addr_i);

  // a taken branch or jal kills both younger stages
  assign flush_o = redirect_i;

endmodule

/* design/fetch_unit.sv */
`include "core_config.svh"

module fetch_unit (
  input  logic            CLK,
  input  logic            RST,
  input  logic            redirect_i,
  input  core_pkg::word_t target_i,
  input  logic            flush_i,
  input  core_pkg::word_t fetch_insn_i,
  output core_pkg::word_t fetch_addr_o,
  output logic            id_valid_o,
  output core_pkg::word_t id_pc_o,
  output core_pkg::word_t id_insn_o
);
  import core_pkg::*;

  // address whose word is on fetch_insn_i this cycle
  word_t ret_pc_q;
  logic  ret_valid_q;

  // program counter, presented every cycle
  always_ff @(posedge CLK) begin
    if (RST) begin
      fetch_addr_o <= `CORE_START_ADDR;
    end else if (redirect_i) begin
      fetch_addr_o <= target_i;
    end else begin
      fetch_addr_o <= fetch_addr_o + `CORE_PC_STEP;
    end
  end

  // the address register holds a fetch that a redirect kills
  always_ff @(posedge CLK) begin
    if (RST) begin
      ret_valid_q <= 1'b0;
      id_valid_o  <= 1'b0;
    end else begin
      ret_valid_q <= !flush_i;
      id_valid_o  <= ret_valid_q && !flush_i;
    end
  end

  always_ff @(posedge CLK) begin
    ret_pc_q  <= fetch_addr_o;
    id_pc_o   <= ret_pc_q;
    id_insn_o <= fetch_insn_i;
  end

  // branch and jal targets keep the low bits clear
  a_fetch_aligned: assert property (
    @(posedge CLK) disable iff (RST) fetch_addr_o[1:0] == 2'b00
  );

endmodule

/* common/core_pkg.sv */
package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////////////////////////////////////////

  // data, address and instruction word
  typedef logic [31:0] word_t;

  // register index
  typedef logic [4:0] reg_addr_t;

  // sign-extended immediate
  typedef logic [31:0] imm_t;

  ////////////////////////////////////////////////////////////////////////////
  // operation encodings
  ////////////////////////////////////////////////////////////////////////////

  // pass_b forwards operand b untouched, used by lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_t;

  // control flow kind resolved in execute
  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_JAL
  } branch_op_t;

  // operand source for execute
  typedef enum logic {
    FWD_NONE,
    FWD_WB
  } fwd_sel_t;

endpackage

/* common/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// program counter value coming out of reset
`define CORE_START_ADDR 32'h0000_0000

// architectural integer registers, x0 included
`define CORE_NUM_REGS 32

// bytes per instruction, no compressed support
`define CORE_PC_STEP 32'd4

`endif
